// File: common/md_pkg.sv
package md_pkg;

	// datapath width of the core
	localparam int XLEN = 32;

	// opcode values follow the decoder of the core
	// bit 1 picks divide, bit 0 picks signed
	typedef enum logic [1:0]
	{
		MULTU = 2'b00,
		MULT  = 2'b01,
		DIVU  = 2'b10,
		DIV   = 2'b11
	} md_op_t;

	// one operation as handed over by the execute stage
	typedef struct packed
	{
		md_op_t          op;
		logic [XLEN-1:0] a;    // dividend or multiplicand
		logic [XLEN-1:0] b;    // divisor or multiplier
	} md_req_t;

	// HI/LO pair
	// multiply: upper and lower product halves
	// divide: remainder in hi, quotient in lo
	typedef struct packed
	{
		logic [XLEN-1:0] hi;
		logic [XLEN-1:0] lo;
	} md_result_t;

	// shift-subtract steps of the divider, one per quotient bit
	localparam int DIV_STEPS = XLEN;

	// setup cycle plus the steps
	localparam int DIV_CYCLES = DIV_STEPS + 1;

endpackage

// File: design/md_multiplier.sv
module md_multiplier #(
	parameter int MUL_STAGES = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               issue,
	input  md_pkg::md_req_t    issue_req,
	output logic               mul_done,
	output md_pkg::md_result_t mul_result
);

	localparam int W = md_pkg::XLEN;

	logic                  is_mul;
	logic                  is_signed;
	logic signed [W:0]     opa;
	logic signed [W:0]     opb;
	logic signed [2*W+1:0] full_prod;

	logic [MUL_STAGES-1:0] vld_q;
	logic [2*W-1:0]        prod_q [MUL_STAGES];

	assign is_mul    = (issue_req.op == md_pkg::MULT) || (issue_req.op == md_pkg::MULTU);
	assign is_signed = issue_req.op == md_pkg::MULT;

	// one extra bit makes a single signed multiply cover both flavours
	assign opa = {is_signed & issue_req.a[W-1], issue_req.a};
	assign opb = {is_signed & issue_req.b[W-1], issue_req.b};

	assign full_prod = opa * opb;

	// valid tag travels alongside the product
	always_ff @(posedge clk)
	begin
		if (!rst)
			vld_q <= '0;
		else
		begin
			vld_q[0] <= issue && is_mul;
			for (int i = 1; i < MUL_STAGES; i++)
				vld_q[i] <= vld_q[i-1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue && is_mul)
			prod_q[0] <= full_prod[2*W-1:0];    // upper two bits are sign copies
		for (int i = 1; i < MUL_STAGES; i++)
			prod_q[i] <= prod_q[i-1];
	end

	assign mul_done      = vld_q[MUL_STAGES-1];
	assign mul_result.hi = prod_q[MUL_STAGES-1][2*W-1:W];
	assign mul_result.lo = prod_q[MUL_STAGES-1][W-1:0];

endmodule

// File: divider/md_divider.sv
module md_divider (
	input  logic               clk,
	input  logic               rst,
	input  logic               issue,
	input  md_pkg::md_req_t    issue_req,
	output logic               div_done,
	output md_pkg::md_result_t div_result
);

	localparam int W     = md_pkg::XLEN;
	localparam int STEPS = md_pkg::DIV_STEPS;
	localparam int CNT_W = $clog2(STEPS);

	localparam logic [CNT_W-1:0] LAST = CNT_W'(STEPS - 1);

	logic         is_div;
	logic         is_signed;
	logic         a_neg;
	logic         b_neg;
	logic [W-1:0] a_mag;
	logic [W-1:0] b_mag;

	logic             active_q;
	logic             done_q;
	logic [CNT_W-1:0] cnt_q;

	logic [W-1:0] rem_q;
	logic [W-1:0] quo_q;    // dividend bits shift out, quotient bits shift in
	logic [W-1:0] dvs_q;
	logic         neg_quo_q;
	logic         neg_rem_q;
	md_pkg::md_result_t res_q;

	logic [W:0]   shifted;
	logic [W:0]   diff;
	logic         fits;
	logic [W-1:0] rem_n;
	logic [W-1:0] quo_n;

	assign is_div    = (issue_req.op == md_pkg::DIV) || (issue_req.op == md_pkg::DIVU);
	assign is_signed = issue_req.op == md_pkg::DIV;

	assign a_neg = is_signed && issue_req.a[W-1];
	assign b_neg = is_signed && issue_req.b[W-1];

	// 0x80000000 maps onto itself, read as unsigned it is the right magnitude
	assign a_mag = a_neg ? -issue_req.a : issue_req.a;
	assign b_mag = b_neg ? -issue_req.b : issue_req.b;

	// one restoring step
	always_comb
	begin
		shifted = {rem_q, quo_q[W-1]};
		diff    = shifted - {1'b0, dvs_q};
		fits    = shifted >= {1'b0, dvs_q};
		rem_n   = fits ? diff[W-1:0] : shifted[W-1:0];
		quo_n   = {quo_q[W-2:0], fits};
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			active_q <= 1'b0;
			done_q   <= 1'b0;
			cnt_q    <= '0;
		end
		else
		begin
			done_q <= 1'b0;
			if (issue && is_div)
			begin
				active_q <= 1'b1;    // setup cycle
				cnt_q    <= '0;
			end
			else if (active_q)
			begin
				cnt_q <= cnt_q + 1'b1;
				if (cnt_q == LAST)
				begin
					active_q <= 1'b0;
					done_q   <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue && is_div)
		begin
			rem_q     <= '0;
			quo_q     <= a_mag;
			dvs_q     <= b_mag;
			neg_quo_q <= a_neg ^ b_neg;
			neg_rem_q <= a_neg;    // remainder follows the dividend
		end
		else if (active_q)
		begin
			rem_q <= rem_n;
			quo_q <= quo_n;
			// sign fix-up rides on the final step
			if (cnt_q == LAST)
			begin
				res_q.lo <= neg_quo_q ? -quo_n : quo_n;
				res_q.hi <= neg_rem_q ? -rem_n : rem_n;
			end
		end
	end

	assign div_done   = done_q;
	assign div_result = res_q;

endmodule

// File: design/md_hilo_ctrl.sv
module md_hilo_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  md_pkg::md_req_t         req,
	input  logic                    start,
	input  logic                    flush,
	input  logic                    hilo_wr,
	input  logic                    hilo_wr_hi,
	input  logic [md_pkg::XLEN-1:0] wr_data,
	input  logic                    rd_hi,
	input  logic                    mul_done,
	input  md_pkg::md_result_t      mul_result,
	input  logic                    div_done,
	input  md_pkg::md_result_t      div_result,
	output logic                    issue,
	output md_pkg::md_req_t         issue_req,
	output logic                    busy,
	output logic [md_pkg::XLEN-1:0] rdata
);

	logic               busy_q;
	logic               unit_done;
	md_pkg::md_result_t hilo_q;

	// no queue, a start while busy is simply dropped
	assign issue     = start && !busy_q && !flush;
	assign issue_req = req;

	assign unit_done = mul_done || div_done;

	always_ff @(posedge clk)
	begin
		if (!rst)
			busy_q <= 1'b0;
		else if (issue)
			busy_q <= 1'b1;
		else if (unit_done)
			busy_q <= 1'b0;    // drops together with the HI/LO update
	end

	// a unit result wins over a move-to write
	always_ff @(posedge clk)
	begin
		if (!rst)
			hilo_q <= '0;
		else if (mul_done)
			hilo_q <= mul_result;
		else if (div_done)
			hilo_q <= div_result;
		else if (hilo_wr && !flush)
		begin
			if (hilo_wr_hi)
				hilo_q.hi <= wr_data;
			else
				hilo_q.lo <= wr_data;
		end
	end

	assign busy  = busy_q;
	assign rdata = rd_hi ? hilo_q.hi : hilo_q.lo;

endmodule

// File: design/md_top.sv
module md_top #(
	parameter int MUL_STAGES = 4
) (
	input  logic                    clk,
	input  logic                    rst,
	input  md_pkg::md_req_t         req,
	input  logic                    start,
	input  logic                    flush,
	input  logic                    hilo_wr,
	input  logic                    hilo_wr_hi,
	input  logic [md_pkg::XLEN-1:0] wr_data,
	input  logic                    rd_hi,
	output logic                    busy,
	output logic [md_pkg::XLEN-1:0] rdata
);

	logic               issue;
	md_pkg::md_req_t    issue_req;
	logic               mul_done;
	md_pkg::md_result_t mul_result;
	logic               div_done;
	md_pkg::md_result_t div_result;

	md_hilo_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.start      (start),
		.flush      (flush),
		.hilo_wr    (hilo_wr),
		.hilo_wr_hi (hilo_wr_hi),
		.wr_data    (wr_data),
		.rd_hi      (rd_hi),
		.mul_done   (mul_done),
		.mul_result (mul_result),
		.div_done   (div_done),
		.div_result (div_result),
		.issue      (issue),
		.issue_req  (issue_req),
		.busy       (busy),
		.rdata      (rdata)
	);

	// both units see every issue and pick out their own opcodes
	md_multiplier #(
		.MUL_STAGES (MUL_STAGES)
	) u_mul (
		.clk        (clk),
		.rst        (rst),
		.issue      (issue),
		.issue_req  (issue_req),
		.mul_done   (mul_done),
		.mul_result (mul_result)
	);

	md_divider u_div (
		.clk        (clk),
		.rst        (rst),
		.issue      (issue),
		.issue_req  (issue_req),
		.div_done   (div_done),
		.div_result (div_result)
	);

endmodule

// File: dv/md_tb_clk.sv
module md_tb_clk (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;    // 10 ns period
	end

	// reset held low for ten rising edges
	initial
	begin
		rst = 1'b0;
		repeat (10) @(posedge clk);
		#1 rst = 1'b1;
	end

endmodule

// File: dv/md_sva.sv
module md_sva (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic mul_done,
	input logic div_done
);
	timeunit 1ns;
	timeprecision 1ps;

	idle_after_reset: assert property (@(posedge clk) $rose(rst) |-> !busy)
		else $error("busy high in the first cycle after reset");

	// a stray result while idle would overwrite HI/LO behind a move-to write
	done_only_when_busy: assert property (@(posedge clk) disable iff (!rst)
		(mul_done || div_done) |-> busy)
		else $error("done strobe while no operation was in flight");

	// only one operation is ever in flight
	single_done: assert property (@(posedge clk) disable iff (!rst) !(mul_done && div_done))
		else $error("multiplier and divider done together");

	done_is_strobe: assert property (@(posedge clk) disable iff (!rst)
		(mul_done || div_done) |=> !(mul_done || div_done))
		else $error("done strobe held for more than one cycle");

endmodule

bind md_hilo_ctrl md_sva u_sva (.*);

// File: dv/md_tb.sv
module md_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MUL_STAGES = 4;
	localparam int TIMEOUT    = 100;    // cycles allowed per wait

	logic                    clk;
	logic                    rst;
	md_pkg::md_req_t         req;
	logic                    start;
	logic                    flush;
	logic                    hilo_wr;
	logic                    hilo_wr_hi;
	logic [md_pkg::XLEN-1:0] wr_data;
	logic                    rd_hi;
	logic                    busy;
	logic [md_pkg::XLEN-1:0] rdata;

	logic [31:0]        lcg_state;
	md_pkg::md_result_t model;    // HI/LO as they should stand
	md_pkg::md_result_t exp_res;
	string              check_name;
	int                 check_seq;
	int                 done_seq;
	int                 n_checks;
	int                 value_errors;
	int                 other_errors;

	md_tb_clk u_clk (.clk(clk), .rst(rst));

	md_top #(.MUL_STAGES(MUL_STAGES)) u_dut (.*);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic md_pkg::md_req_t make_req(md_pkg::md_op_t op, logic [31:0] a,
		logic [31:0] b);
		md_pkg::md_req_t r;
		r.op = op;
		r.a  = a;
		r.b  = b;
		return r;
	endfunction

	// expected HI/LO pair for one operation
	function automatic md_pkg::md_result_t md_ref(md_pkg::md_req_t r);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [63:0] q;
		logic signed [63:0] m;
		md_pkg::md_result_t res;
		sa = {{32{r.a[31]}}, r.a};
		sb = {{32{r.b[31]}}, r.b};
		case (r.op)
			md_pkg::MULT:  res = sa * sb;
			md_pkg::MULTU: res = {32'b0, r.a} * {32'b0, r.b};
			md_pkg::DIV:
			begin
				q   = sa / sb;    // min / -1 wraps back to min once truncated
				m   = sa % sb;    // sign follows the dividend
				res = {m[31:0], q[31:0]};
			end
			default:
			begin
				res.hi = r.a % r.b;
				res.lo = r.a / r.b;
			end
		endcase
		return res;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_idle(output int cycles);
		cycles = 0;
		while (busy && cycles < TIMEOUT)
		begin
			step();
			cycles++;
		end
		if (busy)
		begin
			$display("timeout waiting for busy to fall");
			other_errors++;
		end
	endtask

	// posts an expected pair to the compare process
	task automatic compare_hilo(input string name, input md_pkg::md_result_t exp);
		int polls;
		check_name = name;
		exp_res    = exp;
		check_seq++;
		polls = 0;
		while (done_seq != check_seq && polls < TIMEOUT)
		begin
			step();
			polls++;
		end
		if (done_seq != check_seq)
		begin
			$display("timeout waiting for the compare process");
			other_errors++;
		end
	endtask

	task automatic run_op(input string name, input md_pkg::md_op_t op, input logic [31:0] a,
		input logic [31:0] b);
		md_pkg::md_req_t r;
		int cycles;
		int lat;
		r     = make_req(op, a, b);
		lat   = (op == md_pkg::MULT || op == md_pkg::MULTU) ? MUL_STAGES : md_pkg::DIV_CYCLES;
		req   = r;
		start = 1'b1;
		step();
		start = 1'b0;
		assert (busy) else
		begin
			$display("%s: busy did not rise after an accepted start", name);
			other_errors++;
		end
		wait_idle(cycles);
		assert (cycles == lat) else
		begin
			$display("FAIL %s latency: expected %0d, actual %0d", name, lat, cycles);
			other_errors++;
		end
		model = md_ref(r);
		compare_hilo(name, model);
	endtask

	task automatic write_hilo(input logic hi, input logic [31:0] data, input logic fl);
		hilo_wr    = 1'b1;
		hilo_wr_hi = hi;
		wr_data    = data;
		flush      = fl;
		step();
		hilo_wr = 1'b0;
		flush   = 1'b0;
		if (!fl)
		begin
			if (hi)
				model.hi = data;
			else
				model.lo = data;
		end
	endtask

	// compare process, reads HI then LO through rd_hi
	initial
	begin
		md_pkg::md_result_t got;
		rd_hi        = 1'b0;
		done_seq     = 0;
		n_checks     = 0;
		value_errors = 0;
		forever
		begin
			@(posedge clk);
			#2;
			if (done_seq != check_seq)
			begin
				rd_hi = 1'b1;
				#1 got.hi = rdata;
				rd_hi = 1'b0;
				#1 got.lo = rdata;
				n_checks++;
				assert (got.hi == exp_res.hi) else
				begin
					$display("FAIL %s hi: expected %h, actual %h", check_name, exp_res.hi, got.hi);
					value_errors++;
				end
				assert (got.lo == exp_res.lo) else
				begin
					$display("FAIL %s lo: expected %h, actual %h", check_name, exp_res.lo, got.lo);
					value_errors++;
				end
				done_seq = check_seq;
			end
		end
	end

	initial
	begin
		logic [31:0] corner [4];
		logic [31:0] rnd;
		logic [31:0] a;
		logic [31:0] b;
		md_pkg::md_req_t r;
		int cycles;
		lcg_state    = 32'd39749;
		check_seq    = 0;
		other_errors = 0;
		model        = '0;
		req          = '0;
		start        = 1'b0;
		flush        = 1'b0;
		hilo_wr      = 1'b0;
		hilo_wr_hi   = 1'b0;
		wr_data      = '0;
		corner       = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};

		cycles = 0;
		while (!rst && cycles < TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!rst)
		begin
			$display("timeout waiting for reset release");
			other_errors++;
		end
		step();

		foreach (corner[i])
			for (int j = 0; j < 4; j++)
			begin
				run_op($sformatf("mult corner %0d %0d", i, j), md_pkg::MULT, corner[i], corner[j]);
				run_op($sformatf("multu corner %0d %0d", i, j), md_pkg::MULTU, corner[i], corner[j]);
			end
		for (int n = 0; n < 200; n++)
		begin
			rnd = lcg_next();
			a   = lcg_next();
			b   = lcg_next();
			run_op($sformatf("mul random %0d", n), rnd[16] ? md_pkg::MULT : md_pkg::MULTU, a, b);
		end

		run_op("div min by minus one", md_pkg::DIV, 32'h8000_0000, 32'hffff_ffff);
		run_op("div minus 7 by 2", md_pkg::DIV, 32'hffff_fff9, 32'd2);
		run_op("div minus 100 by 7", md_pkg::DIV, 32'hffff_ff9c, 32'd7);
		run_op("divu all ones by 3", md_pkg::DIVU, 32'hffff_ffff, 32'd3);
		for (int n = 0; n < 200; n++)
		begin
			rnd = lcg_next();
			a   = lcg_next();
			b   = lcg_next();
			if (b == 32'd0)
				b = 32'd1;    // divide by zero left unchecked
			run_op($sformatf("div random %0d", n), rnd[16] ? md_pkg::DIV : md_pkg::DIVU, a, b);
		end

		// move-to writes while idle
		write_hilo(1'b1, 32'h1234_5678, 1'b0);
		compare_hilo("write hi", model);
		write_hilo(1'b0, 32'h9abc_def0, 1'b0);
		compare_hilo("write lo", model);

		req   = make_req(md_pkg::MULT, 32'd11, 32'd13);
		start = 1'b1;
		flush = 1'b1;
		step();
		start = 1'b0;
		flush = 1'b0;
		assert (!busy) else
		begin
			$display("busy rose after a start with flush high");
			other_errors++;
		end
		repeat (md_pkg::DIV_CYCLES) step();    // room for a stray result to land
		compare_hilo("flushed start", model);
		write_hilo(1'b0, 32'hdead_beef, 1'b1);
		compare_hilo("flushed lo write", model);

		// second start lands two cycles into the divide
		r     = make_req(md_pkg::DIVU, 32'd1000003, 32'd97);
		req   = r;
		start = 1'b1;
		step();
		start = 1'b0;
		step();
		req   = make_req(md_pkg::MULT, 32'h7, 32'h9);
		start = 1'b1;
		step();
		start = 1'b0;
		wait_idle(cycles);
		model = md_ref(r);
		compare_hilo("start while busy", model);

		$display("checks %0d, value errors %0d, other errors %0d",
			n_checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: build.f
common/md_pkg.sv
design/md_multiplier.sv
divider/md_divider.sv
design/md_hilo_ctrl.sv
design/md_top.sv
dv/md_tb_clk.sv
dv/md_sva.sv
dv/md_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the multiply/divide testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f build.f --top-module md_tb -o md_sim

./obj_dir/md_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
